//--- verilog/phcomp_pkg.sv
// Phase compensation FIFO definitions
`default_nettype none

package phcomp_pkg;

	// data word width
	localparam int dat_width = 8;

	// pointers carry one extra wrap bit above the RAM address width
	localparam int addr_width = 4;
	localparam int depth = 1 << addr_width;

	// flip-flop stages in each pointer synchronizer
	localparam int sync_stages = 2;

	// rd_clk cycles of seen write activity before reads open
	localparam int ptr_gap = 6;

	// local pointer delay ahead of the word count that matches the crossing delay
	localparam int count_stages = 5;

	typedef logic [dat_width-1:0] data_t;
	typedef logic [addr_width:0] ptr_t;
	typedef logic [addr_width-1:0] addr_t;

	typedef struct packed {
		logic  we;
		addr_t addr;
		data_t dat;
	} wr_port_t;

endpackage

`default_nettype wire

//--- verilog/gray_ptr_sync.sv
// Gray pointer synchronizer
`timescale 1ns/1ns
`default_nettype none

module gray_ptr_sync (
	input  logic             clk,
	input  logic             rst,
	input  phcomp_pkg::ptr_t gray_in,
	output phcomp_pkg::ptr_t bin_out
);
	import phcomp_pkg::*;

	ptr_t sync_q [sync_stages];
	ptr_t gray_cap;

	// each binary bit is the xor of all gray bits at and above it
	function automatic ptr_t gray_to_bin(input ptr_t gray);
		ptr_t bin;
		bin[addr_width] = gray[addr_width];
		for (int i = addr_width - 1; i >= 0; i--) begin
			bin[i] = bin[i + 1] ^ gray[i];
		end
		return bin;
	endfunction

	// metastability chain where only one bit of the gray code moves per update
	always_ff @(posedge clk) begin
		sync_q[0] <= gray_in;
		for (int i = 1; i < sync_stages; i++) begin
			sync_q[i] <= sync_q[i - 1];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			gray_cap <= '0;
			bin_out <= '0;
		end else begin
			gray_cap <= sync_q[sync_stages - 1];
			bin_out <= gray_to_bin(gray_cap);
		end
	end

endmodule

`default_nettype wire

//--- verilog/phcomp_ram.sv
// Dual-clock FIFO storage RAM
`timescale 1ns/1ns
`default_nettype none

module phcomp_ram (
	input  logic                 wr_clk,
	input  phcomp_pkg::wr_port_t wr,
	input  logic                 rd_clk,
	input  logic                 rd_en,
	input  phcomp_pkg::addr_t    rd_addr,
	output phcomp_pkg::data_t    rd_dat
);
	import phcomp_pkg::*;

	data_t mem [depth];

	always_ff @(posedge wr_clk) begin
		if (wr.we) begin
			mem[wr.addr] <= wr.dat;
		end
	end

	// the registered read word is held until the next enabled read
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_dat <= mem[rd_addr];
		end
	end

endmodule

`default_nettype wire

//--- verilog/phcomp_dcfifo.sv
// Phase compensation dual-clock FIFO core
`timescale 1ns/1ns
`default_nettype none

module phcomp_dcfifo (
	input  logic              wr_clk,
	input  logic              rst_wr,
	input  logic              wr_req,
	input  phcomp_pkg::data_t wr_dat,
	output logic              wr_full,
	output phcomp_pkg::ptr_t  wr_used,
	input  logic              rd_clk,
	input  logic              rst_rd,
	input  logic              rd_req,
	output logic              rd_ack,
	output logic              rd_empty,
	output phcomp_pkg::data_t rd_dat,
	output phcomp_pkg::ptr_t  rd_used
);
	import phcomp_pkg::*;

	// write domain
	ptr_t     wr_ptr;
	ptr_t     gray_wr_ptr;
	ptr_t     wr_side_rd_ptr;
	ptr_t     wr_ptr_dly [count_stages];
	logic     wr_accept;
	logic     wr_acc_q;
	wr_port_t ram_wr;

	// read domain
	ptr_t                   rd_ptr;
	ptr_t                   gray_rd_ptr;
	ptr_t                   rd_side_wr_ptr;
	ptr_t                   rd_ptr_dly [count_stages];
	logic [sync_stages-1:0] wren_sync;
	logic [ptr_gap-1:0]     rd_gap;
	logic                   gap_in;
	logic                   gap_open;
	logic                   rd_dat_vld;
	data_t                  ram_rd_dat;

	// full when the addresses match but the wrap bits differ
	assign wr_full = (wr_side_rd_ptr[addr_width-1:0] == wr_ptr[addr_width-1:0]) &&
		(wr_side_rd_ptr[addr_width] != wr_ptr[addr_width]);
	assign wr_accept = wr_req & ~wr_full;

	assign ram_wr.we = wr_accept;
	assign ram_wr.addr = wr_ptr[addr_width-1:0];
	assign ram_wr.dat = wr_dat;

	always_ff @(posedge wr_clk or posedge rst_wr) begin
		if (rst_wr) begin
			wr_ptr <= '0;
			gray_wr_ptr <= '0;
			wr_acc_q <= 1'b0;
		end else begin
			gray_wr_ptr <= wr_ptr ^ (wr_ptr >> 1);
			wr_acc_q <= wr_accept;
			if (wr_accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// the local pointer is aged to line up with the crossed read pointer
	always_ff @(posedge wr_clk or posedge rst_wr) begin
		if (rst_wr) begin
			for (int i = 0; i < count_stages; i++) begin
				wr_ptr_dly[i] <= '0;
			end
			wr_used <= '0;
		end else begin
			wr_ptr_dly[0] <= wr_ptr;
			for (int i = 1; i < count_stages; i++) begin
				wr_ptr_dly[i] <= wr_ptr_dly[i - 1];
			end
			wr_used <= wr_ptr_dly[count_stages - 1] - wr_side_rd_ptr;
		end
	end

	gray_ptr_sync u_rd_ptr_sync (
		.clk     (wr_clk),
		.rst     (rst_wr),
		.gray_in (gray_rd_ptr),
		.bin_out (wr_side_rd_ptr)
	);

	gray_ptr_sync u_wr_ptr_sync (
		.clk     (rd_clk),
		.rst     (rst_rd),
		.gray_in (gray_wr_ptr),
		.bin_out (rd_side_wr_ptr)
	);

	assign rd_empty = (rd_side_wr_ptr == rd_ptr);

	// activity is held while words remain so that a stopped writer can still be drained
	assign gap_in = wren_sync[sync_stages-1] | (rd_gap[0] & ~rd_empty);
	assign gap_open = rd_gap[ptr_gap-1];
	assign rd_ack = rd_req & ~rd_empty & gap_open;

	always_ff @(posedge rd_clk or posedge rst_rd) begin
		if (rst_rd) begin
			wren_sync <= '0;
			rd_gap <= '0;
		end else begin
			wren_sync <= {wren_sync[sync_stages-2:0], wr_acc_q};
			rd_gap <= {rd_gap[ptr_gap-2:0], gap_in};
		end
	end

	always_ff @(posedge rd_clk or posedge rst_rd) begin
		if (rst_rd) begin
			rd_ptr <= '0;
			gray_rd_ptr <= '0;
			rd_dat_vld <= 1'b0;
		end else begin
			gray_rd_ptr <= rd_ptr ^ (rd_ptr >> 1);
			if (rd_ack) begin
				rd_ptr <= rd_ptr + 1'b1;
				rd_dat_vld <= 1'b1;
			end
		end
	end

	always_ff @(posedge rd_clk or posedge rst_rd) begin
		if (rst_rd) begin
			for (int i = 0; i < count_stages; i++) begin
				rd_ptr_dly[i] <= '0;
			end
			rd_used <= '0;
		end else begin
			rd_ptr_dly[0] <= rd_ptr;
			for (int i = 1; i < count_stages; i++) begin
				rd_ptr_dly[i] <= rd_ptr_dly[i - 1];
			end
			rd_used <= rd_side_wr_ptr - rd_ptr_dly[count_stages - 1];
		end
	end

	phcomp_ram u_ram (
		.wr_clk  (wr_clk),
		.wr      (ram_wr),
		.rd_clk  (rd_clk),
		.rd_en   (rd_ack),
		.rd_addr (rd_ptr[addr_width-1:0]),
		.rd_dat  (ram_rd_dat)
	);

	// the RAM output register holds no word until the first read lands
	assign rd_dat = rd_dat_vld ? ram_rd_dat : '0;

endmodule

`default_nettype wire

//--- verilog/phcomp_top.sv
// Phase compensation FIFO top level
`timescale 1ns/1ns
`default_nettype none

module phcomp_top (
	input  logic              wr_clk,
	input  logic              rst_wr,
	input  logic              wr_req,
	input  phcomp_pkg::data_t wr_dat,
	output logic              wr_full,
	output phcomp_pkg::ptr_t  wr_used,
	input  logic              rd_clk,
	input  logic              rst_rd,
	input  logic              rd_req,
	output logic              rd_empty,
	output logic              rd_ack,
	output phcomp_pkg::data_t rd_dat,
	output phcomp_pkg::ptr_t  rd_used
);

	phcomp_dcfifo u_dcfifo (
		.wr_clk   (wr_clk),
		.rst_wr   (rst_wr),
		.wr_req   (wr_req),
		.wr_dat   (wr_dat),
		.wr_full  (wr_full),
		.wr_used  (wr_used),
		.rd_clk   (rd_clk),
		.rst_rd   (rst_rd),
		.rd_req   (rd_req),
		.rd_ack   (rd_ack),
		.rd_empty (rd_empty),
		.rd_dat   (rd_dat),
		.rd_used  (rd_used)
	);

endmodule

`default_nettype wire

//--- sim/phcomp_checker.sv
// FIFO core assertions
`timescale 1ns/1ns
`default_nettype none

module phcomp_checker (
	input logic             wr_clk,
	input logic             rst_wr,
	input logic             wr_full,
	input phcomp_pkg::ptr_t wr_ptr,
	input logic             rd_clk,
	input logic             rst_rd,
	input logic             rd_ack,
	input logic             rd_empty
);

	int assert_fails = 0;

	// a request made while full is dropped and the write pointer holds
	ptr_held_when_full: assert property (
		@(posedge wr_clk) disable iff (rst_wr) wr_full |=> $stable(wr_ptr))
	else begin
		assert_fails++;
		$error("write pointer moved while wr_full was high");
	end

	ack_not_empty: assert property (
		@(posedge rd_clk) disable iff (rst_rd) rd_ack |-> !rd_empty)
	else begin
		assert_fails++;
		$error("rd_ack asserted while rd_empty was high");
	end

endmodule

bind phcomp_dcfifo phcomp_checker u_checker (
	.wr_clk   (wr_clk),
	.rst_wr   (rst_wr),
	.wr_full  (wr_full),
	.wr_ptr   (wr_ptr),
	.rd_clk   (rd_clk),
	.rst_rd   (rst_rd),
	.rd_ack   (rd_ack),
	.rd_empty (rd_empty)
);

`default_nettype wire

//--- sim/phcomp_monitor.sv
// Reference FIFO model and scoreboard
`timescale 1ns/1ns
`default_nettype none

module phcomp_monitor (
	input logic              wr_clk,
	input logic              rst_wr,
	input logic              wr_req,
	input phcomp_pkg::data_t wr_dat,
	input logic              wr_full,
	input phcomp_pkg::ptr_t  wr_used,
	input logic              rd_clk,
	input logic              rst_rd,
	input logic              rd_ack,
	input logic              rd_empty,
	input phcomp_pkg::data_t rd_dat,
	input phcomp_pkg::ptr_t  rd_used
);
	import phcomp_pkg::*;

	data_t model_q [$];
	data_t expect_dat;
	logic  expect_vld = 1'b0;
	int    errors = 0;
	int    checks = 0;
	int    tests = 0;
	int    failed = 0;
	int    test_errors = 0;
	logic  full_seen = 1'b0;
	logic  gap_armed = 1'b0;
	logic  gap_started = 1'b0;
	logic  gap_done = 1'b0;
	int    gap_cycles = 0;

	task automatic check(input logic ok, input string msg);
		checks++;
		if (!ok) begin
			errors++;
			$display("[FAIL] %0t ns: %s", $time, msg);
		end
	endtask

	// the write side never sees fewer words than the model holds
	always @(posedge wr_clk) begin
		if (!rst_wr) begin
			if (model_q.size() >= depth) begin
				check(wr_full, "wr_full low with 16 words outstanding");
			end
			check(wr_used <= ptr_t'(depth), "wr_used above the FIFO depth");
			full_seen = full_seen | wr_full;
			if (wr_req && !wr_full) begin
				model_q.push_back(wr_dat);
				gap_started = gap_started | gap_armed;
			end
		end
	end

	// rd_dat is compared one cycle after its rd_ack
	always @(posedge rd_clk) begin
		if (rst_rd) begin
			expect_vld = 1'b0;
		end else begin
			if (expect_vld) begin
				check(rd_dat === expect_dat,
					$sformatf("rd_dat is %h, expected %h", rd_dat, expect_dat));
			end
			expect_vld = 1'b0;
			check(rd_used <= ptr_t'(depth), "rd_used above the FIFO depth");
			if (gap_started) begin
				gap_cycles++;
			end
			if (rd_ack) begin
				check(!rd_empty, "rd_ack asserted while rd_empty was high");
				check(model_q.size() > 0, "rd_ack with no word left in the model");
				if (model_q.size() > 0) begin
					expect_dat = model_q.pop_front();
					expect_vld = 1'b1;
				end
				if (gap_armed) begin
					check(gap_cycles >= ptr_gap, "rd_ack came before the gap gate delay");
					gap_armed = 1'b0;
					gap_done = 1'b1;
				end
			end
		end
	end

	task automatic check_reset();
		check(rd_empty && !wr_full && !rd_ack, "flags not at their reset values");
		check(rd_used == '0 && wr_used == '0, "word counts not zero after reset");
		check(rd_dat == '0, "rd_dat not zero after reset");
	endtask

	task automatic check_drained();
		check(model_q.size() == 0 && rd_empty, "words left in the FIFO after draining");
		check(rd_used == '0 && wr_used == '0, "word counts did not settle to zero");
	endtask

	// the gate is measured from the first write accepted after this call
	task automatic arm_gap_check();
		gap_armed = 1'b1;
		gap_started = 1'b0;
		gap_cycles = 0;
		gap_done = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_errors) begin
			failed++;
		end
		$display("test %0d, %s: %0d errors", tests, name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic report(input int assert_fails);
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests, failed, checks, errors, assert_fails);
	endtask

endmodule

`default_nettype wire

//--- sim/tb_phcomp.sv
// Phase compensation FIFO testbench
`timescale 1ns/1ns
`default_nettype none

module tb_phcomp;
	import phcomp_pkg::*;

	localparam int rd_period = 100;
	localparam int wr_period = 90;
	localparam int reset_cycles = 8;
	// length of each test in rd_clk cycles
	localparam int idle_len = 10;
	localparam int mixed_len = 400;
	localparam int full_len = 60;
	localparam int empty_len = 60;
	localparam int gap_len = 90;
	localparam int total_len = reset_cycles + idle_len + mixed_len + full_len + empty_len +
		gap_len;
	localparam int watchdog_ns = (total_len + 100) * rd_period;

	logic  wr_clk = 1'b0;
	logic  rd_clk = 1'b0;
	logic  rst_wr = 1'b1;
	logic  rst_rd = 1'b1;
	logic  wr_req = 1'b0;
	data_t wr_dat = '0;
	logic  rd_req = 1'b0;
	logic  wr_full;
	ptr_t  wr_used;
	logic  rd_empty;
	logic  rd_ack;
	data_t rd_dat;
	ptr_t  rd_used;
	int    seed = 32'hfc73_8cff;
	// request rates in percent
	int    wr_rate = 0;
	int    rd_rate = 0;

	// the two periods differ so the clock phase drifts
	always #(wr_period / 2) wr_clk = ~wr_clk;
	always #(rd_period / 2) rd_clk = ~rd_clk;

	function automatic int pct();
		return ($random(seed) & 32'h7fff_ffff) % 100;
	endfunction

	always @(posedge wr_clk) begin
		wr_req <= pct() < wr_rate;
		wr_dat <= data_t'($random(seed));
	end

	always @(posedge rd_clk) begin
		rd_req <= pct() < rd_rate;
	end

	phcomp_top uut (
		.wr_clk   (wr_clk),
		.rst_wr   (rst_wr),
		.wr_req   (wr_req),
		.wr_dat   (wr_dat),
		.wr_full  (wr_full),
		.wr_used  (wr_used),
		.rd_clk   (rd_clk),
		.rst_rd   (rst_rd),
		.rd_req   (rd_req),
		.rd_empty (rd_empty),
		.rd_ack   (rd_ack),
		.rd_dat   (rd_dat),
		.rd_used  (rd_used)
	);

	phcomp_monitor u_mon (
		.wr_clk   (wr_clk),
		.rst_wr   (rst_wr),
		.wr_req   (wr_req),
		.wr_dat   (wr_dat),
		.wr_full  (wr_full),
		.wr_used  (wr_used),
		.rd_clk   (rd_clk),
		.rst_rd   (rst_rd),
		.rd_ack   (rd_ack),
		.rd_empty (rd_empty),
		.rd_dat   (rd_dat),
		.rd_used  (rd_used)
	);

	// checks and rate changes happen on the falling edge away from the DUT updates
	task automatic run_cycles(input int n);
		repeat (n) @(posedge rd_clk);
		@(negedge rd_clk);
	endtask

	initial begin
		repeat (reset_cycles) @(posedge rd_clk);
		rst_rd <= 1'b0;
		@(posedge wr_clk);
		rst_wr <= 1'b0;
		run_cycles(idle_len);
		u_mon.check_reset();
		u_mon.end_test("reset state");
		wr_rate <= 45;
		rd_rate <= 55;
		run_cycles(mixed_len);
		u_mon.end_test("random traffic");
		wr_rate <= 100;
		rd_rate <= 0;
		run_cycles(full_len);
		u_mon.check(u_mon.full_seen, "wr_full never rose while writing without reads");
		u_mon.end_test("full");
		wr_rate <= 0;
		rd_rate <= 100;
		run_cycles(empty_len);
		u_mon.check_drained();
		u_mon.end_test("empty and word counts");
		// the long idle stretch above has closed the gate again
		u_mon.arm_gap_check();
		wr_rate <= 30;
		run_cycles(gap_len - 30);
		wr_rate <= 0;
		run_cycles(30);
		u_mon.check(u_mon.gap_done, "no read was accepted in the gap gate test");
		u_mon.check_drained();
		u_mon.end_test("gap gate");
		u_mon.report(uut.u_dcfifo.u_checker.assert_fails);
		if (u_mon.errors == 0 && uut.u_dcfifo.u_checker.assert_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("simulation timed out before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
verilog/phcomp_pkg.sv
verilog/gray_ptr_sync.sv
verilog/phcomp_ram.sv
verilog/phcomp_dcfifo.sv
verilog/phcomp_top.sv
sim/phcomp_checker.sv
sim/phcomp_monitor.sv
sim/tb_phcomp.sv

//--- run.sh
#!/bin/sh
# build and run the phase compensation FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_phcomp -f all.f -o sim_phcomp

status=0
./obj_dir/sim_phcomp +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation finished without failures"
